//--- Makefile
# Verilator build and run of the divide / square-root testbench

VERILATOR ?= verilator
TOP       ?= tb_divsqrt
FILELIST  ?= divsqrt.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- divsqrt.f
divsqrt_pkg.sv
divsqrt_fsm.sv
iter_counter.sv
divsqrt_datapath.sv
divsqrt_top.sv
divsqrt_chk.sv
tb_divsqrt.sv

//--- divsqrt_chk.sv
// divide / square-root unit protocol checker
// latency, stall stability, reset and flush assertions, bound into the top level

module divsqrt_chk (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  divsqrt_pkg::req_t  req_i,
  input  logic               in_valid_i,
  input  logic               in_ready_i,
  input  logic               flush_i,
  input  divsqrt_pkg::rsp_t  rsp_i,
  input  logic               out_valid_i,
  input  logic               out_ready_i,
  input  logic               busy_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned LAT_DIV  = divsqrt_pkg::ITER_DIV + 1;  // 33 edges
  localparam int unsigned LAT_SQRT = divsqrt_pkg::ITER_SQRT + 1; // 17 edges

  int unsigned                   fail_cnt = 0; // read by the testbench at the end
  logic                          accept;
  logic [divsqrt_pkg::CNT_W-1:0] wait_q;       // edges left until the result shows

  assign accept = in_valid_i & in_ready_i & ~flush_i;

  // --------------------
  // latency tracker
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q <= '0;
    end else if (flush_i) begin
      wait_q <= '0;                                // flushed op never delivers
    end else if (accept) begin
      wait_q <= (req_i.op == divsqrt_pkg::OP_DIV) ? divsqrt_pkg::CNT_W'(LAT_DIV)
                                                  : divsqrt_pkg::CNT_W'(LAT_SQRT);
    end else if (wait_q != '0) begin
      wait_q <= wait_q - divsqrt_pkg::CNT_W'(1);
    end
  end

  // --------------------
  // assertions
  // --------------------
  // no result while the op is still iterating, and the unit shows busy
  a_lat_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
    (wait_q != '0) |-> (!out_valid_i && busy_i))
    else begin fail_cnt++; $error("out_valid_o high or busy_o low while iterating"); end

  // result shows exactly on the last tracked edge
  a_lat_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
    (wait_q == divsqrt_pkg::CNT_W'(1)) |=> out_valid_i)
    else begin fail_cnt++; $error("out_valid_o missing at the expected latency"); end

  // stalled response holds still
  a_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(rsp_i)))
    else begin fail_cnt++; $error("response changed or dropped while stalled"); end

  a_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> (!out_valid_i && !busy_i && in_ready_i))
    else begin fail_cnt++; $error("outputs not idle during reset"); end

  a_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |-> (!out_valid_i && !busy_i))
    else begin fail_cnt++; $error("out_valid_o or busy_o high in a flush cycle"); end

endmodule

bind divsqrt_top divsqrt_chk chk0 (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_i       (req_i),
  .in_valid_i  (in_valid_i),
  .in_ready_i  (in_ready_o),
  .flush_i     (flush_i),
  .rsp_i       (rsp_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_i      (busy_o)
);

//--- divsqrt_datapath.sv
// iterative divide / square-root datapath
// restoring unsigned division and digit-by-digit integer square root, one bit per step

module divsqrt_datapath (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               start_i,  // capture req_i
  input  logic               step_i,   // one iteration
  input  divsqrt_pkg::req_t  req_i,
  output divsqrt_pkg::op_e   op_o,     // opcode for the counter
  output divsqrt_pkg::rsp_t  rsp_o
);

  // --------------------
  // registers
  // --------------------
  logic [divsqrt_pkg::DATA_W-1:0] a_q;    // dividend / radicand, shifted out msb first
  logic [divsqrt_pkg::DATA_W-1:0] b_q;    // divisor
  logic [divsqrt_pkg::DATA_W-1:0] rem_q;  // partial remainder
  logic [divsqrt_pkg::DATA_W-1:0] res_q;  // quotient or root, bits shift in at lsb
  divsqrt_pkg::op_e               op_q;
  logic [divsqrt_pkg::TAG_W-1:0]  tag_q;
  logic                           mask_q;
  logic                           dz_q;   // division by zero seen at start

  // --------------------
  // iteration step
  // --------------------
  // two extra bits so both step kinds compare without overflow
  logic [divsqrt_pkg::DATA_W+1:0] rem_sh;  // remainder with next bit(s) brought down
  logic [divsqrt_pkg::DATA_W+1:0] trial;   // value to subtract
  logic [divsqrt_pkg::DATA_W+1:0] diff;
  logic                           fits;    // new result bit
  logic [divsqrt_pkg::DATA_W-1:0] a_nxt;
  logic [divsqrt_pkg::DATA_W-1:0] rem_nxt;
  logic [divsqrt_pkg::DATA_W-1:0] res_nxt;

  always_comb begin
    if (op_q == divsqrt_pkg::OP_DIV) begin
      // restoring division: one dividend bit into the remainder
      rem_sh = {1'b0, rem_q, a_q[divsqrt_pkg::DATA_W-1]};
      trial  = {2'b00, b_q};                                // b = 0 always fits -> all ones
      a_nxt  = {a_q[divsqrt_pkg::DATA_W-2:0], 1'b0};
    end else begin
      // square root: two radicand bits, try 4*root + 1
      rem_sh = {rem_q, a_q[divsqrt_pkg::DATA_W-1 -: 2]};
      trial  = {res_q, 2'b01};
      a_nxt  = {a_q[divsqrt_pkg::DATA_W-3:0], 2'b00};
    end
    fits    = (rem_sh >= trial);
    diff    = rem_sh - trial;
    // remainder stays below divisor or below 2*root+1, so the low word is enough
    rem_nxt = fits ? diff[divsqrt_pkg::DATA_W-1:0] : rem_sh[divsqrt_pkg::DATA_W-1:0];
    res_nxt = {res_q[divsqrt_pkg::DATA_W-2:0], fits};
  end

  // --------------------
  // operand registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_q <= req_i.a;
      b_q <= req_i.b;
    end else if (step_i) begin
      a_q <= a_nxt;              // consumed bits drop off the top
    end
  end

  // --------------------
  // result and sideband
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rem_q  <= '0;
      res_q  <= '0;
      op_q   <= divsqrt_pkg::OP_DIV;
      tag_q  <= '0;
      mask_q <= 1'b0;
      dz_q   <= 1'b0;
    end else if (start_i) begin
      rem_q  <= '0;              // fresh operation
      res_q  <= '0;
      op_q   <= req_i.op;
      tag_q  <= req_i.tag;
      mask_q <= req_i.mask;
      dz_q   <= (req_i.op == divsqrt_pkg::OP_DIV) && (req_i.b == '0);
    end else if (step_i) begin
      rem_q <= rem_nxt;
      res_q <= res_nxt;
    end
    // otherwise everything holds, which keeps rsp_o stable while stalled
  end

  // counter loads on the start cycle, before op_q is written
  assign op_o = start_i ? req_i.op : op_q;

  // --------------------
  // response
  // --------------------
  assign rsp_o.result    = res_q;
  assign rsp_o.status.dz = dz_q;
  assign rsp_o.status.nx = |rem_q;  // inexact quotient / not a perfect square
  assign rsp_o.tag       = tag_q;
  assign rsp_o.mask      = mask_q;

endmodule

//--- divsqrt_fsm.sv
// divide / square-root control FSM
// input and output valid/ready handshakes, flush and busy indication

module divsqrt_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  // upstream handshake
  input  logic in_valid_i,
  output logic in_ready_o,
  // downstream handshake
  output logic out_valid_o,
  input  logic out_ready_i,
  // control
  input  logic flush_i,
  input  logic done_i,     // level from the iteration counter
  output logic start_o,    // to counter and datapath
  output logic busy_o
);

  divsqrt_pkg::state_e state_q, state_d;

  // --------------------
  // next state / outputs
  // --------------------
  always_comb begin
    // defaults
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      divsqrt_pkg::IDLE: begin
        in_ready_o = 1'b1;                         // free, take anything
        if (in_valid_i) begin
          state_d = divsqrt_pkg::BUSY;
        end
      end

      divsqrt_pkg::BUSY: begin
        busy_o = 1'b1;                             // operation in flight
        if (done_i) begin
          out_valid_o = 1'b1;                      // offer the result
          if (out_ready_i) begin
            in_ready_o = 1'b1;                     // slot frees this cycle
            // back-to-back if a new request is waiting
            state_d = in_valid_i ? divsqrt_pkg::BUSY : divsqrt_pkg::IDLE;
          end else begin
            state_d = divsqrt_pkg::HOLD;           // downstream stalls
          end
        end
      end

      divsqrt_pkg::HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;                        // result regs untouched until next start
        if (out_ready_i) begin
          in_ready_o = 1'b1;
          state_d    = in_valid_i ? divsqrt_pkg::BUSY : divsqrt_pkg::IDLE;
        end
      end

      default: begin
        state_d = divsqrt_pkg::IDLE;               // recover from illegal encoding
      end
    endcase

    // flush wins over everything
    if (flush_i) begin
      out_valid_o = 1'b0;                          // drop the pending result
      busy_o      = 1'b0;
      state_d     = divsqrt_pkg::IDLE;
    end
  end

  // a request offered together with flush is swallowed, never started
  assign start_o = in_valid_i & in_ready_o & ~flush_i;

  // --------------------
  // state register
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= divsqrt_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- divsqrt_pkg.sv
// divide / square-root unit shared definitions
// widths, iteration counts, opcode and state enums, request and response structs

package divsqrt_pkg;

  // --------------------
  // widths and counts
  // --------------------
  localparam int unsigned DATA_W    = 32; // operand and result width
  localparam int unsigned ITER_DIV  = 32; // one quotient bit per iteration
  localparam int unsigned ITER_SQRT = 16; // one root bit per iteration, two radicand bits
  localparam int unsigned CNT_W     = 6;  // must hold ITER_DIV
  localparam int unsigned TAG_W     = 4;  // request tag width

  // --------------------
  // enums
  // --------------------
  typedef enum logic {
    OP_DIV  = 1'b0, // unsigned a / b
    OP_SQRT = 1'b1  // floor(sqrt(a)), b ignored
  } op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0, // waiting for work
    BUSY = 2'd1, // iterating, or result offered for the first time
    HOLD = 2'd2  // result stalled by downstream
  } state_e;

  // --------------------
  // structs
  // --------------------
  typedef struct packed {
    logic dz; // divide by zero
    logic nx; // remainder nonzero
  } status_t;

  typedef struct packed {
    logic [DATA_W-1:0] a;    // dividend or radicand
    logic [DATA_W-1:0] b;    // divisor
    op_e               op;
    logic [TAG_W-1:0]  tag;
    logic              mask;
  } req_t;

  typedef struct packed {
    logic [DATA_W-1:0] result; // quotient or root
    status_t           status;
    logic [TAG_W-1:0]  tag;    // returned as requested
    logic              mask;
  } rsp_t;

endpackage

//--- divsqrt_top.sv
// divide / square-root unit top level
// control FSM, iteration counter and datapath

module divsqrt_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // request side
  input  divsqrt_pkg::req_t  req_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  logic               flush_i,
  // response side
  output divsqrt_pkg::rsp_t  rsp_o,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  // operation in flight
  output logic               busy_o
);

  logic             start;  // accept with no flush
  logic             step;   // datapath iteration
  logic             done;   // result ready in datapath regs
  divsqrt_pkg::op_e op;     // opcode seen by the counter

  // --------------------
  // control
  // --------------------
  divsqrt_fsm u_fsm (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .flush_i     (flush_i),
    .done_i      (done),
    .start_o     (start),
    .busy_o      (busy_o)
  );

  iter_counter u_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (start),
    .flush_i  (flush_i),
    .op_i     (op),       // N = 32 div, 16 sqrt
    .step_o   (step),
    .done_o   (done)
  );

  // --------------------
  // datapath
  // --------------------
  divsqrt_datapath u_dp (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (start),
    .step_i   (step),
    .req_i    (req_i),
    .op_o     (op),
    .rsp_o    (rsp_o)     // held until the next start
  );

endmodule

//--- iter_counter.sv
// iteration counter for the divide / square-root datapath
// loads the per-opcode count on start, steps the datapath and flags completion

module iter_counter (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  logic              flush_i,
  input  divsqrt_pkg::op_e  op_i,    // valid on the start cycle
  output logic              step_o,  // one datapath iteration this cycle
  output logic              done_o   // held until next start or flush
);

  logic [divsqrt_pkg::CNT_W-1:0] cnt_q;   // iterations left
  logic [divsqrt_pkg::CNT_W-1:0] load_val;
  logic                          run_q;   // counting
  logic                          done_q;

  assign load_val = (op_i == divsqrt_pkg::OP_DIV) ? divsqrt_pkg::CNT_W'(divsqrt_pkg::ITER_DIV)
                                                  : divsqrt_pkg::CNT_W'(divsqrt_pkg::ITER_SQRT);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      done_q <= 1'b0;
    end else if (flush_i) begin
      cnt_q  <= '0;        // abandon the operation
      run_q  <= 1'b0;
      done_q <= 1'b0;
    end else if (start_i) begin
      cnt_q  <= load_val;
      run_q  <= 1'b1;
      done_q <= 1'b0;      // previous result consumed
    end else if (run_q) begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        run_q  <= 1'b0;    // all bits in, result settles here
        done_q <= 1'b1;
      end
    end
  end

  assign step_o = run_q & (cnt_q != '0);
  assign done_o = done_q;

endmodule

//--- tb_divsqrt.sv
// testbench for the divide / square-root unit
// random divide, square root, divide by zero, back-pressure and flush runs against a reference

module tb_divsqrt;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned N_DIV   = 16;
  localparam int unsigned N_SQRT  = 16;
  localparam int unsigned N_DZ    = 4;
  localparam int unsigned N_BP    = 8;  // two ops each
  localparam int unsigned N_FL    = 4;  // flushed op plus follow-up
  localparam int unsigned NUM_OPS = N_DIV + N_SQRT + N_DZ + 2 * N_BP + 2 * N_FL;
  localparam int unsigned TIMEOUT_CYC = NUM_OPS * 40 + 500;

  logic              clk;
  logic              arst_n;
  divsqrt_pkg::req_t req;
  logic              in_valid, in_ready, flush;
  divsqrt_pkg::rsp_t rsp;
  logic              out_valid, out_ready, busy;

  integer            seed;
  int unsigned       cycle_cnt = 0;
  int unsigned       err_cnt   = 0;
  int unsigned       check_cnt = 0;
  int unsigned       test_cnt  = 0;

  divsqrt_top dut0 (
    .clk_i (clk), .arst_n_i (arst_n),
    .req_i (req), .in_valid_i (in_valid), .in_ready_o (in_ready), .flush_i (flush),
    .rsp_o (rsp), .out_valid_o (out_valid), .out_ready_i (out_ready), .busy_o (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, the DUT stopped delivering results", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // reference model
  // --------------------
  function automatic logic [15:0] floor_sqrt(input logic [31:0] x);
    longint unsigned lo, hi, mid;
    lo = 0;
    hi = 65535;
    while (lo < hi) begin          // binary search on the root
      mid = (lo + hi + 1) / 2;
      if (mid * mid <= x) lo = mid;
      else hi = mid - 1;
    end
    return 16'(lo);
  endfunction

  function automatic divsqrt_pkg::rsp_t expected_rsp(input divsqrt_pkg::req_t r);
    divsqrt_pkg::rsp_t e;
    logic [31:0]       root;
    e.tag  = r.tag;
    e.mask = r.mask;
    e.status.dz = 1'b0;
    if (r.op == divsqrt_pkg::OP_SQRT) begin
      root = {16'h0, floor_sqrt(r.a)};
      e.result    = root;
      e.status.nx = (root * root != r.a);
    end else if (r.b == '0) begin
      e.result    = '1;              // remainder keeps the dividend
      e.status.dz = 1'b1;
      e.status.nx = (r.a != '0);
    end else begin
      e.result    = r.a / r.b;
      e.status.nx = (r.a % r.b) != '0;
    end
    return e;
  endfunction

  // --------------------
  // checks and reporting
  // --------------------
  task automatic compare_field(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s %s expected %0h actual %0h", name, field, exp, act);
    end
  endtask

  task automatic compare_rsp(input string name, input divsqrt_pkg::req_t r,
                             input divsqrt_pkg::rsp_t act);
    divsqrt_pkg::rsp_t exp;
    exp = expected_rsp(r);
    compare_field(name, "result", exp.result, act.result);
    compare_field(name, "status", {30'h0, exp.status}, {30'h0, act.status});
    compare_field(name, "tag", {28'h0, exp.tag}, {28'h0, act.tag});
    compare_field(name, "mask", {31'h0, exp.mask}, {31'h0, act.mask});
  endtask

  // value mismatches plus assertion failures so far
  function automatic int unsigned fail_total();
    return err_cnt + dut0.chk0.fail_cnt;
  endfunction

  task automatic report_test(input string name, input int unsigned fails_before);
    test_cnt++;
    if (fail_total() == fails_before) $display("test %s ok", name);
    else $display("test %s %0d errors", name, fail_total() - fails_before);
  endtask

  // --------------------
  // stimulus
  // --------------------
  task automatic random_req(input divsqrt_pkg::op_e op, output divsqrt_pkg::req_t r);
    logic [31:0] rnd, rnd2, rnd3;
    rnd  = $random(seed);
    rnd2 = $random(seed);
    rnd3 = $random(seed);
    r.op   = op;
    r.tag  = rnd2[8 +: divsqrt_pkg::TAG_W];
    r.mask = rnd2[12];
    if (op == divsqrt_pkg::OP_DIV) begin
      r.a = rnd;
      r.b = rnd3 >> rnd2[4:0];     // spread the quotient size
      if (r.b == '0) r.b = 32'd1;
    end else begin
      r.b = '0;
      if (rnd2[5]) r.a = {16'h0, rnd[15:0]} * {16'h0, rnd[15:0]}; // perfect square
      else r.a = rnd >> rnd2[4:0];
    end
  endtask

  task automatic issue(input divsqrt_pkg::req_t r);
    @(posedge clk);
    req      <= r;
    in_valid <= 1'b1;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);                // accept edge
    in_valid <= 1'b0;
  endtask

  task automatic hold_result(input string name, input int unsigned stall,
                             output divsqrt_pkg::rsp_t got);
    bit held;
    @(negedge clk);
    while (!out_valid) @(negedge clk);
    got  = rsp;
    held = 1'b1;
    repeat (stall) begin
      @(negedge clk);
      if (!out_valid || rsp !== got) held = 1'b0;
    end
    check_cnt++;
    if (!held) begin
      err_cnt++;
      $display("%s: response changed or dropped while stalled", name);
    end
  endtask

  task automatic await_rsp(output divsqrt_pkg::rsp_t got);
    out_ready <= 1'b1;             // take the result as soon as it shows
    @(negedge clk);
    while (!out_valid) @(negedge clk);
    got = rsp;
    @(posedge clk);                // consume edge
  endtask

  task automatic run_op(input string name, input divsqrt_pkg::req_t r);
    divsqrt_pkg::rsp_t got;
    issue(r);
    await_rsp(got);
    compare_rsp(name, r, got);
  endtask

  // second request offered in the cycle the first result is consumed
  task automatic back_to_back(input string name, input divsqrt_pkg::req_t r1,
                              input divsqrt_pkg::req_t r2, input int unsigned stall);
    divsqrt_pkg::rsp_t got;
    bit                took;
    issue(r1);
    out_ready <= 1'b0;
    hold_result(name, stall, got);
    @(posedge clk);
    out_ready <= 1'b1;
    req       <= r2;
    in_valid  <= 1'b1;
    @(negedge clk);
    took = in_ready;
    check_cnt++;
    if (!took) begin
      err_cnt++;
      $display("%s: second request not accepted in the consume cycle", name);
    end
    @(posedge clk);                // consume and accept together
    in_valid <= 1'b0;
    compare_rsp({name, ".first"}, r1, got);
    if (took) begin
      await_rsp(got);
      compare_rsp({name, ".second"}, r2, got);
    end
  endtask

  task automatic flush_op(input string name, input divsqrt_pkg::req_t r, input int unsigned delay);
    bit seen;
    issue(r);
    repeat (delay) @(posedge clk);  // still iterating
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    seen = 1'b0;
    repeat (40) begin
      @(negedge clk);
      if (out_valid) seen = 1'b1;
    end
    check_cnt++;
    if (seen) begin
      err_cnt++;
      $display("%s: a result appeared for the flushed operation", name);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    divsqrt_pkg::req_t r, r2;
    int unsigned       base;
    logic [31:0]       rnd;
    seed      = 94835;
    arst_n    = 1'b0;
    req       = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    repeat (10) @(posedge clk);
    arst_n    <= 1'b1;
    out_ready <= 1'b1;

    base = fail_total();
    for (int i = 0; i < N_DIV; i++) begin
      random_req(divsqrt_pkg::OP_DIV, r);
      run_op($sformatf("div_random[%0d]", i), r);
    end
    report_test("div_random", base);

    base = fail_total();
    for (int i = 0; i < N_SQRT; i++) begin
      random_req(divsqrt_pkg::OP_SQRT, r);
      if (i == 0) r.a = 32'hffff_ffff;  // largest radicand
      run_op($sformatf("sqrt_random[%0d]", i), r);
    end
    report_test("sqrt_random", base);

    base = fail_total();
    for (int i = 0; i < N_DZ; i++) begin
      random_req(divsqrt_pkg::OP_DIV, r);
      r.b = '0;
      if (i == 0) r.a = '0;            // exact, no nx
      run_op($sformatf("div_by_zero[%0d]", i), r);
    end
    report_test("div_by_zero", base);

    base = fail_total();
    for (int i = 0; i < N_BP; i++) begin
      random_req(i[0] ? divsqrt_pkg::OP_SQRT : divsqrt_pkg::OP_DIV, r);
      random_req(i[1] ? divsqrt_pkg::OP_SQRT : divsqrt_pkg::OP_DIV, r2);
      rnd = $random(seed);
      back_to_back($sformatf("back_pressure[%0d]", i), r, r2, 1 + (rnd % 6));
    end
    report_test("back_pressure", base);

    base = fail_total();
    for (int i = 0; i < N_FL; i++) begin
      random_req(divsqrt_pkg::OP_DIV, r);
      rnd = $random(seed);
      flush_op($sformatf("flush[%0d]", i), r, 2 + (rnd % 25));
      random_req(i[0] ? divsqrt_pkg::OP_SQRT : divsqrt_pkg::OP_DIV, r);
      run_op($sformatf("flush[%0d].after", i), r);
    end
    report_test("flush", base);

    repeat (5) @(posedge clk);
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_cnt, check_cnt, err_cnt, dut0.chk0.fail_cnt);
    if (err_cnt == 0 && dut0.chk0.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
